/* design/htif_pkg.sv */
// bridge types and constants; reduced AXI without IDs or response codes, 64-bit bus only
package htif_pkg;

    localparam int data_w = 64;

    // master-driven side of the reduced bus
    typedef struct packed {
        logic                  aw_valid;
        logic [data_w-1:0]     aw_addr;
        logic [7:0]            aw_len;
        logic                  w_valid;
        logic [data_w-1:0]     w_data;
        logic [data_w/8-1:0]   w_strb;
        logic                  w_last;
        logic                  b_ready;
        logic                  ar_valid;
        logic [data_w-1:0]     ar_addr;
        logic [7:0]            ar_len;
        logic                  r_ready;
    } axi_req_t;

    // slave-driven side, every response is OKAY
    typedef struct packed {
        logic                  aw_ready;
        logic                  w_ready;
        logic                  b_valid;
        logic                  ar_ready;
        logic                  r_valid;
        logic [data_w-1:0]     r_data;
        logic                  r_last;
    } axi_rsp_t;

    typedef enum logic [1:0] {
        op_rd_stat,                                  // status register poll
        op_rd_rx,                                    // pop Rx FIFO
        op_wr_tx                                     // push Tx FIFO
    } uart_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_reg,                                      // plain register access
        st_poll,                                     // waiting on status read
        st_tx,
        st_rx,
        st_recover
    } console_state_t;

    // UART-lite register map
    localparam logic [data_w-1:0]   uart_status_off  = 64'h8;
    localparam int                  stat_rx_valid    = 0;
    localparam int                  stat_tx_full     = 3;

    // HTIF tohost/frhost fields
    localparam logic [7:0]          htif_console_dev = 8'd1;
    localparam logic [7:0]          htif_cmd_write   = 8'd1;
    localparam logic [7:0]          htif_cmd_read    = 8'd0;

    localparam logic [data_w/8-1:0] tx_strobe        = 8'b0001_0000;   // byte 4, Tx FIFO lane

endpackage

/* design/htif_route.sv */
// only single-beat (len 0) accesses to tohost/frhost are captured; bursts to them pass through
`timescale 1ns/1ps

module htif_route #(
    parameter logic [htif_pkg::data_w-1:0] tohost_addr = 64'h0,
    parameter logic [htif_pkg::data_w-1:0] frhost_addr = 64'h0
) (
    input  htif_pkg::axi_req_t up_req,
    input  htif_pkg::axi_rsp_t dn_rsp,
    input  htif_pkg::axi_rsp_t regs_rsp,
    input  htif_pkg::axi_req_t uart_req,
    input  logic               busy,
    output htif_pkg::axi_rsp_t up_rsp,
    output htif_pkg::axi_req_t dn_req,
    output logic               htif_sel
);

    logic ar_hit;
    logic aw_hit;

    // single-beat HTIF read request
    always_comb begin
        ar_hit = up_req.ar_valid && up_req.ar_len == 8'd0 &&
                 (up_req.ar_addr == tohost_addr || up_req.ar_addr == frhost_addr);
    end

    // single-beat HTIF write request
    always_comb begin
        aw_hit = up_req.aw_valid && up_req.aw_len == 8'd0 &&
                 (up_req.aw_addr == tohost_addr || up_req.aw_addr == frhost_addr);
    end

    assign htif_sel = ar_hit | aw_hit | busy;

    // upstream responses come from the local slave while selected
    always_comb begin
        if (htif_sel) begin
            up_rsp = regs_rsp;
        end else begin
            up_rsp = dn_rsp;
        end
    end

    // downstream only ever sees the UART master while selected
    always_comb begin
        if (htif_sel) begin
            dn_req = uart_req;
        end else begin
            dn_req = up_req;
        end
    end

endmodule

/* design/htif_regs.sv */
// write strobes are ignored, HTIF registers are always written as full 64-bit words
`timescale 1ns/1ps

module htif_regs #(
    parameter logic [htif_pkg::data_w-1:0] tohost_addr = 64'h0,
    parameter logic [htif_pkg::data_w-1:0] frhost_addr = 64'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  htif_pkg::axi_req_t up_req,
    input  logic               htif_sel,
    input  logic               hold,
    input  logic               tx_clear,
    input  logic               rx_load,
    input  logic [7:0]         rx_byte,
    output htif_pkg::axi_rsp_t regs_rsp,
    output logic               rd_done,
    output logic               poll_rx,
    output logic               wr_done,
    output logic               console_tx,
    output logic [31:0]        tx_char
);
    import htif_pkg::*;

    logic [data_w-1:0] tohost_q;
    logic [data_w-1:0] frhost_q;
    logic [data_w-1:0] waddr_q;
    logic [data_w-1:0] wdata_q;
    logic [data_w-1:0] rdata_q;
    logic              ar_ready_q;
    logic              aw_ready_q;
    logic              w_ready_q;
    logic              r_valid_q;
    logic              b_valid_q;
    logic              fr_empty_q;                  // read hit an empty frhost
    logic              ar_xfer;
    logic              aw_xfer;
    logic              w_xfer;
    logic              wr_commit;
    logic              tohost_console;

    always_comb begin
        regs_rsp.aw_ready = aw_ready_q & ~hold;
        regs_rsp.w_ready  = w_ready_q & ~hold;
        regs_rsp.b_valid  = b_valid_q;
        regs_rsp.ar_ready = ar_ready_q & ~hold;
        regs_rsp.r_valid  = r_valid_q;
        regs_rsp.r_data   = rdata_q;
        regs_rsp.r_last   = 1'b1;
    end

    assign ar_xfer   = htif_sel & up_req.ar_valid & regs_rsp.ar_ready;
    assign aw_xfer   = htif_sel & up_req.aw_valid & regs_rsp.aw_ready;
    assign w_xfer    = htif_sel & up_req.w_valid & regs_rsp.w_ready;
    assign wr_commit = htif_sel & ~aw_ready_q & ~w_ready_q & ~b_valid_q & ~hold;
    assign rd_done   = htif_sel & r_valid_q & up_req.r_ready;
    assign wr_done   = htif_sel & b_valid_q & up_req.b_ready;

    assign tohost_console = waddr_q == tohost_addr &&
                            tohost_q[63:56] == htif_console_dev &&
                            tohost_q[55:48] == htif_cmd_write;

    assign poll_rx    = rd_done & fr_empty_q;
    assign console_tx = wr_done & tohost_console;
    assign tx_char    = tohost_q[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost_q   <= '0;
            frhost_q   <= '0;
            ar_ready_q <= 1'b1;
            aw_ready_q <= 1'b1;
            w_ready_q  <= 1'b1;
            r_valid_q  <= 1'b0;
            b_valid_q  <= 1'b0;
            fr_empty_q <= 1'b0;
        end else begin
            if (ar_xfer) begin
                ar_ready_q <= 1'b0;
                r_valid_q  <= 1'b1;
                fr_empty_q <= up_req.ar_addr == frhost_addr && frhost_q == '0;
            end
            if (rd_done) begin
                r_valid_q  <= 1'b0;
                ar_ready_q <= 1'b1;
            end
            if (aw_xfer) aw_ready_q <= 1'b0;
            if (w_xfer) w_ready_q <= 1'b0;
            if (wr_commit) begin                     // address and data both held
                b_valid_q <= 1'b1;
                if (waddr_q == tohost_addr) tohost_q <= wdata_q;
                if (waddr_q == frhost_addr) frhost_q <= wdata_q;
            end
            if (wr_done) begin
                b_valid_q  <= 1'b0;
                aw_ready_q <= 1'b1;
                w_ready_q  <= 1'b1;
                if (!tohost_console) tohost_q <= '0;  // non-console command consumed
            end
            if (tx_clear) tohost_q <= '0;
            if (rx_load) begin
                frhost_q <= {htif_console_dev, htif_cmd_read, {(data_w - 24){1'b0}}, rx_byte};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_xfer) rdata_q <= (up_req.ar_addr == tohost_addr) ? tohost_q : frhost_q;
        if (aw_xfer) waddr_q <= up_req.aw_addr;
        if (w_xfer) wdata_q <= up_req.w_data;
    end

endmodule

/* design/uart_access.sv */
// one outstanding access at a time; op_start must only pulse while the previous op is done
`timescale 1ns/1ps

module uart_access #(
    parameter logic [htif_pkg::data_w-1:0] uart_base = 64'h1000_0000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          op_start,
    input  htif_pkg::uart_op_t            op,
    input  logic [31:0]                   tx_char,
    input  htif_pkg::axi_rsp_t            dn_rsp,
    output htif_pkg::axi_req_t            uart_req,
    output logic                          op_done,
    output logic [htif_pkg::data_w-1:0]   op_data
);
    import htif_pkg::*;

    logic              ar_valid_q;
    logic              r_ready_q;
    logic              aw_valid_q;
    logic              w_valid_q;
    logic              b_ready_q;
    logic              wr_wait_q;                   // write issued, AW/W not both done
    logic [data_w-1:0] addr_q;
    logic              r_xfer;
    logic              b_xfer;

    assign r_xfer  = r_ready_q & dn_rsp.r_valid;
    assign b_xfer  = b_ready_q & dn_rsp.b_valid;
    assign op_done = r_xfer | b_xfer;
    assign op_data = dn_rsp.r_data;

    always_comb begin
        uart_req.aw_valid = aw_valid_q;
        uart_req.aw_addr  = addr_q;
        uart_req.aw_len   = 8'd0;
        uart_req.w_valid  = w_valid_q;
        uart_req.w_data   = {tx_char, {(data_w - 32){1'b0}}};  // char in upper word
        uart_req.w_strb   = tx_strobe;
        uart_req.w_last   = 1'b1;
        uart_req.b_ready  = b_ready_q;
        uart_req.ar_valid = ar_valid_q;
        uart_req.ar_addr  = addr_q;
        uart_req.ar_len   = 8'd0;
        uart_req.r_ready  = r_ready_q;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid_q <= 1'b0;
            r_ready_q  <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            b_ready_q  <= 1'b0;
            wr_wait_q  <= 1'b0;
        end else begin
            if (op_start) begin
                if (op == op_wr_tx) begin
                    aw_valid_q <= 1'b1;
                    w_valid_q  <= 1'b1;
                    wr_wait_q  <= 1'b1;
                end else begin
                    ar_valid_q <= 1'b1;
                end
            end
            if (ar_valid_q && dn_rsp.ar_ready) begin
                ar_valid_q <= 1'b0;
                r_ready_q  <= 1'b1;
            end
            if (r_xfer) r_ready_q <= 1'b0;
            if (aw_valid_q && dn_rsp.aw_ready) aw_valid_q <= 1'b0;
            if (w_valid_q && dn_rsp.w_ready) w_valid_q <= 1'b0;
            if (wr_wait_q && !aw_valid_q && !w_valid_q) begin
                wr_wait_q <= 1'b0;
                b_ready_q <= 1'b1;
            end
            if (b_xfer) b_ready_q <= 1'b0;
        end
    end

    // Tx and Rx FIFO share the base address
    always_ff @(posedge clk) begin
        if (op_start) addr_q <= (op == op_rd_stat) ? uart_base + uart_status_off : uart_base;
    end

endmodule

/* design/htif_ctrl.sv */
// Tx-full polling has no limit, a UART that never drains keeps the bridge busy
`timescale 1ns/1ps

module htif_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          htif_sel,
    input  logic                          rd_done,
    input  logic                          poll_rx,
    input  logic                          wr_done,
    input  logic                          console_tx,
    input  logic                          op_done,
    input  logic [htif_pkg::data_w-1:0]   op_data,
    output logic                          busy,
    output logic                          hold,
    output logic                          op_start,
    output htif_pkg::uart_op_t            op,
    output logic                          tx_clear,
    output logic                          rx_load,
    output logic [7:0]                    rx_byte
);
    import htif_pkg::*;

    console_state_t state;
    logic           rx_job;                          // current job is a console read

    assign busy = state != st_idle;
    assign hold = state inside {st_poll, st_tx, st_rx, st_recover};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            rx_job   <= 1'b0;
            op_start <= 1'b0;
            op       <= op_rd_stat;
            tx_clear <= 1'b0;
            rx_load  <= 1'b0;
        end else begin
            op_start <= 1'b0;
            tx_clear <= 1'b0;
            rx_load  <= 1'b0;
            case (state)
                st_idle: begin
                    if (htif_sel) state <= st_reg;
                end
                st_reg: begin
                    if (rd_done) begin
                        if (poll_rx) begin           // empty frhost, check for input
                            rx_job   <= 1'b1;
                            op_start <= 1'b1;
                            op       <= op_rd_stat;
                            state    <= st_poll;
                        end else begin
                            state <= st_idle;
                        end
                    end else if (wr_done) begin
                        if (console_tx) begin
                            rx_job   <= 1'b0;
                            op_start <= 1'b1;
                            op       <= op_rd_stat;
                            state    <= st_poll;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                st_poll: begin
                    if (op_done) begin
                        if (rx_job) begin
                            if (op_data[stat_rx_valid]) begin
                                op_start <= 1'b1;
                                op       <= op_rd_rx;
                                state    <= st_rx;
                            end else begin
                                state <= st_recover;  // nothing received
                            end
                        end else if (op_data[stat_tx_full]) begin
                            op_start <= 1'b1;        // poll again
                            op       <= op_rd_stat;
                        end else begin
                            op_start <= 1'b1;
                            op       <= op_wr_tx;
                            state    <= st_tx;
                        end
                    end
                end
                st_tx: begin
                    if (op_done) begin
                        tx_clear <= 1'b1;
                        state    <= st_recover;
                    end
                end
                st_rx: begin
                    if (op_done) begin
                        rx_load <= 1'b1;
                        state   <= st_recover;
                    end
                end
                st_recover: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_rx && op_done) rx_byte <= op_data[7:0];
    end

endmodule

/* design/htif_uart_bridge.sv */
// HTIF addresses must not overlap any downstream target; concurrent read and write to them unsupported
`timescale 1ns/1ps

module htif_uart_bridge #(
    parameter logic [htif_pkg::data_w-1:0] tohost_addr = 64'h8000_1000,
    parameter logic [htif_pkg::data_w-1:0] frhost_addr = 64'h8000_1040,
    parameter logic [htif_pkg::data_w-1:0] uart_base   = 64'h1000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  htif_pkg::axi_req_t up_req,
    output htif_pkg::axi_rsp_t up_rsp,
    output htif_pkg::axi_req_t dn_req,
    input  htif_pkg::axi_rsp_t dn_rsp
);
    import htif_pkg::*;

    axi_rsp_t          regs_rsp;
    axi_req_t          uart_req;
    logic              htif_sel;
    logic              busy;
    logic              hold;
    logic              tx_clear;
    logic              rx_load;
    logic [7:0]        rx_byte;
    logic              rd_done;
    logic              poll_rx;
    logic              wr_done;
    logic              console_tx;
    logic [31:0]       tx_char;
    logic              op_start;
    uart_op_t          op;
    logic              op_done;
    logic [data_w-1:0] op_data;

    htif_route #(
        .tohost_addr (tohost_addr),
        .frhost_addr (frhost_addr)
    ) htif_route_i (
        .up_req   (up_req),
        .dn_rsp   (dn_rsp),
        .regs_rsp (regs_rsp),
        .uart_req (uart_req),
        .busy     (busy),
        .up_rsp   (up_rsp),
        .dn_req   (dn_req),
        .htif_sel (htif_sel)
    );

    htif_regs #(
        .tohost_addr (tohost_addr),
        .frhost_addr (frhost_addr)
    ) htif_regs_i (
        .clk        (clk),
        .rst        (rst),
        .up_req     (up_req),
        .htif_sel   (htif_sel),
        .hold       (hold),
        .tx_clear   (tx_clear),
        .rx_load    (rx_load),
        .rx_byte    (rx_byte),
        .regs_rsp   (regs_rsp),
        .rd_done    (rd_done),
        .poll_rx    (poll_rx),
        .wr_done    (wr_done),
        .console_tx (console_tx),
        .tx_char    (tx_char)
    );

    htif_ctrl htif_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .htif_sel   (htif_sel),
        .rd_done    (rd_done),
        .poll_rx    (poll_rx),
        .wr_done    (wr_done),
        .console_tx (console_tx),
        .op_done    (op_done),
        .op_data    (op_data),
        .busy       (busy),
        .hold       (hold),
        .op_start   (op_start),
        .op         (op),
        .tx_clear   (tx_clear),
        .rx_load    (rx_load),
        .rx_byte    (rx_byte)
    );

    uart_access #(
        .uart_base (uart_base)
    ) uart_access_i (
        .clk      (clk),
        .rst      (rst),
        .op_start (op_start),
        .op       (op),
        .tx_char  (tx_char),
        .dn_rsp   (dn_rsp),
        .uart_req (uart_req),
        .op_done  (op_done),
        .op_data  (op_data)
    );

endmodule

/* bench/htif_uart_bridge_assertions.sv */
// reference model assumes one upstream access at a time and AW with W driven together
`timescale 1ns/1ps

module htif_uart_bridge_assertions #(
    parameter logic [htif_pkg::data_w-1:0] tohost_addr = 64'h0,
    parameter logic [htif_pkg::data_w-1:0] frhost_addr = 64'h0,
    parameter logic [htif_pkg::data_w-1:0] uart_base   = 64'h0
) (
    input logic               clk,
    input logic               rst,
    input htif_pkg::axi_req_t up_req,
    input htif_pkg::axi_rsp_t up_rsp,
    input htif_pkg::axi_req_t dn_req,
    input htif_pkg::axi_rsp_t dn_rsp
);
    import htif_pkg::*;

    logic [data_w-1:0] tohost_m, frhost_m, rd_exp, wa, wd, dn_addr;
    logic              rd_pend, wr_pend, reg_q, rd_poll, console_q, rx_job, tx_pend, stat_ok;
    logic [1:0]        end_cnt;
    logic              failed = 1'b0;
    logic              up_hit, ht_ar_xfer, ht_aw_xfer, up_w_xfer, up_r_xfer, up_b_xfer;
    logic              dn_ar_xfer, dn_aw_xfer, dn_w_xfer, dn_r_xfer, dn_b_xfer, quiet;

    assign up_hit = (up_req.ar_valid && up_req.ar_len == 8'd0 &&
                     (up_req.ar_addr == tohost_addr || up_req.ar_addr == frhost_addr)) ||
                    (up_req.aw_valid && up_req.aw_len == 8'd0 &&
                     (up_req.aw_addr == tohost_addr || up_req.aw_addr == frhost_addr));
    assign ht_ar_xfer = up_req.ar_valid && up_rsp.ar_ready && up_req.ar_len == 8'd0 &&
                        (up_req.ar_addr == tohost_addr || up_req.ar_addr == frhost_addr);
    assign ht_aw_xfer = up_req.aw_valid && up_rsp.aw_ready && up_req.aw_len == 8'd0 &&
                        (up_req.aw_addr == tohost_addr || up_req.aw_addr == frhost_addr);
    assign up_w_xfer  = up_req.w_valid && up_rsp.w_ready && (wr_pend || ht_aw_xfer);
    assign up_r_xfer  = rd_pend && up_rsp.r_valid && up_req.r_ready;
    assign up_b_xfer  = wr_pend && up_rsp.b_valid && up_req.b_ready;
    assign dn_ar_xfer = dn_req.ar_valid && dn_rsp.ar_ready;
    assign dn_aw_xfer = dn_req.aw_valid && dn_rsp.aw_ready;
    assign dn_w_xfer  = dn_req.w_valid && dn_rsp.w_ready;
    assign dn_r_xfer  = dn_rsp.r_valid && dn_req.r_ready;
    assign dn_b_xfer  = dn_rsp.b_valid && dn_req.b_ready;
    assign quiet      = !reg_q && !console_q && end_cnt == 2'd0 && !up_hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            {tohost_m, frhost_m} <= '0;
            {rd_pend, wr_pend, reg_q, rd_poll, console_q, rx_job, tx_pend, stat_ok} <= '0;
            end_cnt <= '0;
        end else begin
            if (end_cnt != 2'd0) end_cnt <= end_cnt - 2'd1;
            if (ht_ar_xfer) begin
                rd_pend <= 1'b1;
                reg_q   <= 1'b1;
                rd_exp  <= (up_req.ar_addr == tohost_addr) ? tohost_m : frhost_m;
                rd_poll <= up_req.ar_addr == frhost_addr && frhost_m == '0;
            end
            if (up_r_xfer) begin
                rd_pend <= 1'b0;
                reg_q   <= 1'b0;
                if (rd_poll) {console_q, rx_job, stat_ok} <= 3'b110;  // empty frhost starts a poll
            end
            if (ht_aw_xfer) begin
                wr_pend <= 1'b1;
                reg_q   <= 1'b1;
                wa      <= up_req.aw_addr;
            end
            if (up_w_xfer) wd <= up_req.w_data;
            if (up_b_xfer) begin
                wr_pend <= 1'b0;
                reg_q   <= 1'b0;
                if (wa == frhost_addr) frhost_m <= wd;
                if (wa == tohost_addr) begin
                    if (wd[63:56] == htif_console_dev && wd[55:48] == htif_cmd_write) begin
                        tohost_m <= wd;
                        {tx_pend, console_q, rx_job, stat_ok} <= 4'b1100;
                    end else begin
                        tohost_m <= '0;
                    end
                end
            end
            if (console_q && dn_ar_xfer) dn_addr <= dn_req.ar_addr;
            if (console_q && dn_r_xfer) begin
                if (dn_addr != uart_base + uart_status_off) begin
                    frhost_m  <= {htif_console_dev, htif_cmd_read, 40'd0, dn_rsp.r_data[7:0]};
                    console_q <= 1'b0;
                    end_cnt   <= 2'd2;
                end else if (rx_job) begin
                    stat_ok <= dn_rsp.r_data[stat_rx_valid];
                    if (!dn_rsp.r_data[stat_rx_valid]) begin
                        console_q <= 1'b0;           // nothing to receive
                        end_cnt   <= 2'd2;
                    end
                end else begin
                    stat_ok <= !dn_rsp.r_data[stat_tx_full];
                end
            end
            if (console_q && dn_aw_xfer) tx_pend <= 1'b0;
            if (console_q && dn_b_xfer) begin
                tohost_m  <= '0;
                tx_pend   <= 1'b0;
                console_q <= 1'b0;
                end_cnt   <= 2'd2;
            end
        end
    end

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        up_r_xfer |-> up_rsp.r_data == rd_exp)
        else begin
            $error("Error at %0t: HTIF read data differs from model", $time);
            failed = 1'b1;
        end

    a_isolate: assert property (@(posedge clk) disable iff (rst)
        console_q |-> !up_rsp.ar_ready && !up_rsp.aw_ready)
        else begin
            $error("Error at %0t: upstream accepted during console", $time);
            failed = 1'b1;
        end

    // Rx FIFO read only after a status poll showed Rx data
    a_dn_read: assert property (@(posedge clk) disable iff (rst)
        console_q && dn_req.ar_valid |->
            dn_req.ar_addr == ((rx_job && stat_ok) ? uart_base : uart_base + uart_status_off))
        else begin
            $error("Error at %0t: console read at wrong UART register", $time);
            failed = 1'b1;
        end

    a_tx_addr: assert property (@(posedge clk) disable iff (rst)
        console_q && dn_aw_xfer |-> tx_pend && stat_ok && dn_req.aw_addr == uart_base)
        else begin
            $error("Error at %0t: unexpected Tx FIFO write", $time);
            failed = 1'b1;
        end

    a_tx_data: assert property (@(posedge clk) disable iff (rst)
        console_q && dn_w_xfer |->
            dn_req.w_strb == tx_strobe && dn_req.w_data[63:32] == tohost_m[31:0])
        else begin
            $error("Error at %0t: Tx FIFO data or strobe wrong", $time);
            failed = 1'b1;
        end

    a_pass: assert property (@(posedge clk) disable iff (rst)
        quiet |-> dn_req == up_req && up_rsp == dn_rsp)
        else begin
            $error("Error at %0t: pass-through path altered", $time);
            failed = 1'b1;
        end

endmodule

bind htif_uart_bridge htif_uart_bridge_assertions #(
    .tohost_addr (tohost_addr),
    .frhost_addr (frhost_addr),
    .uart_base   (uart_base)
) assertions_i (
    .clk    (clk),
    .rst    (rst),
    .up_req (up_req),
    .up_rsp (up_rsp),
    .dn_req (dn_req),
    .dn_rsp (dn_rsp)
);

/* bench/htif_uart_bridge_tb.sv */
// one upstream access at a time; downstream model serves one read and one write at a time
`timescale 1ns/1ps

module htif_uart_bridge_tb;
    import htif_pkg::*;

    localparam logic [63:0] tohost = 64'h8000_1000;
    localparam logic [63:0] frhost = 64'h8000_1040;
    localparam logic [63:0] ubase  = 64'h1000_0000;
    localparam int          limit  = 200;

    logic        clk, rst;
    axi_req_t    up_req, dn_req;
    axi_rsp_t    up_rsp, dn_rsp;
    logic [63:0] ram [logic [63:0]];
    logic [63:0] rd_addr, wr_addr, wr_data;
    logic        rd_busy, aw_got, w_got, rx_valid;
    int          rd_wait, tx_full_polls;
    logic [7:0]  rx_char;

    htif_uart_bridge #(
        .tohost_addr (tohost),
        .frhost_addr (frhost),
        .uart_base   (ubase)
    ) htif_uart_bridge_i (
        .clk    (clk),
        .rst    (rst),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    always #2 clk = ~clk;

    task automatic expire(input string what);
        $display("Test failed");
        $fatal(1, "timeout while waiting for %s", what);
    endtask

    task automatic check_flag();
        if (htif_uart_bridge_i.assertions_i.failed) begin
            $display("Test failed");
            $fatal(1, "a bridge assertion failed");
        end
    endtask

    task automatic drive_read(input logic [63:0] addr);
        int n;
        up_req.ar_valid = 1'b1;
        up_req.ar_addr  = addr;
        up_req.r_ready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) expire("read address ready");
        end while (!up_rsp.ar_ready);
        @(posedge clk);
        #1 up_req.ar_valid = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) expire("read data valid");
        end while (!up_rsp.r_valid);
        @(posedge clk);
        #1 up_req.r_ready = 1'b0;
        check_flag();
    endtask

    task automatic drive_write(input logic [63:0] addr, input logic [63:0] data);
        int  n;
        logic aw_now, w_now;
        up_req.aw_valid = 1'b1;
        up_req.aw_addr  = addr;
        up_req.w_valid  = 1'b1;
        up_req.w_data   = data;
        up_req.b_ready  = 1'b1;
        n = 0;
        while (up_req.aw_valid || up_req.w_valid) begin
            @(negedge clk);
            aw_now = up_req.aw_valid && up_rsp.aw_ready;
            w_now  = up_req.w_valid && up_rsp.w_ready;
            @(posedge clk);
            #1;
            if (aw_now) up_req.aw_valid = 1'b0;
            if (w_now) up_req.w_valid = 1'b0;
            n++;
            if (n > limit) expire("write address and data ready");
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) expire("write response valid");
        end while (!up_rsp.b_valid);
        @(posedge clk);
        #1 up_req.b_ready = 1'b0;
        check_flag();
    endtask

    // console sequence over once both upstream readies return
    task automatic wait_console_end();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) expire("end of console sequence");
        end while (!(up_rsp.ar_ready && up_rsp.aw_ready));
        @(posedge clk);
        #1 check_flag();
    endtask

    // downstream UART-lite model with RAM behind it
    initial begin : downstream_model
        logic ar_x, r_x, aw_x, w_x, b_x;
        forever begin
            @(negedge clk);
            ar_x = !rst && dn_req.ar_valid && dn_rsp.ar_ready;
            r_x  = !rst && dn_rsp.r_valid && dn_req.r_ready;
            aw_x = !rst && dn_req.aw_valid && dn_rsp.aw_ready;
            w_x  = !rst && dn_req.w_valid && dn_rsp.w_ready;
            b_x  = !rst && dn_rsp.b_valid && dn_req.b_ready;
            if (ar_x) rd_addr = dn_req.ar_addr;
            if (aw_x) wr_addr = dn_req.aw_addr;
            if (w_x) wr_data = dn_req.w_data;
            @(posedge clk);
            #1;
            if (r_x) dn_rsp.r_valid = 1'b0;
            if (b_x) dn_rsp.b_valid = 1'b0;
            if (ar_x) begin
                rd_busy = 1'b1;
                rd_wait = $urandom % 3;
            end
            if (aw_x) aw_got = 1'b1;
            if (w_x) w_got = 1'b1;
            if (rd_busy && !dn_rsp.r_valid) begin
                if (rd_wait == 0) begin
                    if (rd_addr == ubase + 64'h8) begin
                        dn_rsp.r_data = {60'd0, tx_full_polls > 0, 2'b00, rx_valid};
                        if (tx_full_polls > 0) tx_full_polls--;
                    end else if (rd_addr == ubase) begin
                        dn_rsp.r_data = {56'd0, rx_char};
                        rx_valid = 1'b0;
                    end else if (ram.exists(rd_addr)) begin
                        dn_rsp.r_data = ram[rd_addr];
                    end else begin
                        dn_rsp.r_data = rd_addr ^ {rd_addr[31:0], rd_addr[63:32]} ^ 64'h5a5a;
                    end
                    dn_rsp.r_valid = 1'b1;
                    rd_busy = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            if (aw_got && w_got && !dn_rsp.b_valid) begin
                if (wr_addr != ubase) ram[wr_addr] = wr_data;
                dn_rsp.b_valid = 1'b1;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            dn_rsp.ar_ready = !rd_busy && !dn_rsp.r_valid && ($urandom % 4 != 0);
            dn_rsp.aw_ready = !aw_got && !dn_rsp.b_valid && ($urandom % 4 != 0);
            dn_rsp.w_ready  = !w_got && !dn_rsp.b_valid && ($urandom % 4 != 0);
        end
    end

    initial begin
        void'($urandom(93190));
        clk = 1'b0;
        rst = 1'b1;
        up_req = '0;
        up_req.w_strb = 8'hff;
        up_req.w_last = 1'b1;
        dn_rsp = '0;
        dn_rsp.r_last = 1'b1;
        {rd_busy, aw_got, w_got, rx_valid} = '0;
        tx_full_polls = 0;
        rx_char = 8'h0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        drive_write(64'h2000, 64'h0123_4567_89ab_cdef);   // pass-through
        drive_read(64'h2000);
        drive_read(64'h3008);

        drive_write(frhost, 64'h0000_0000_dead_beef);
        drive_read(frhost);
        drive_write(tohost, 64'h0000_0000_0000_0042);     // not a console command
        wait_console_end();
        drive_read(tohost);

        tx_full_polls = 1 + $urandom % 4;
        drive_write(tohost, {8'd1, 8'd1, 16'd0, 32'h0000_0041});
        wait_console_end();
        drive_read(tohost);

        drive_write(frhost, 64'd0);
        rx_valid = 1'b1;
        rx_char  = 8'($urandom % 256);
        drive_read(frhost);                               // empty frhost starts a poll
        wait_console_end();
        drive_read(frhost);
        drive_write(frhost, 64'd0);
        drive_read(frhost);                               // Rx empty this time
        wait_console_end();
        drive_read(frhost);
        wait_console_end();

        for (int i = 0; i < 4; i++) begin
            drive_write(64'h4000 + 8 * i, {$urandom, $urandom});
            drive_read(64'h4000 + 8 * i);
        end

        if (htif_uart_bridge_i.assertions_i.failed) begin
            $display("Test failed");
            $fatal(1, "a bridge assertion failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* flist.f */
design/htif_pkg.sv
design/htif_route.sv
design/htif_regs.sv
design/uart_access.sv
design/htif_ctrl.sv
design/htif_uart_bridge.sv
bench/htif_uart_bridge_assertions.sv
bench/htif_uart_bridge_tb.sv

/* Bender.yml */
package:
  name: htif_uart_bridge

sources:
  - design/htif_pkg.sv
  - design/htif_route.sv
  - design/htif_regs.sv
  - design/uart_access.sv
  - design/htif_ctrl.sv
  - design/htif_uart_bridge.sv
  - target: simulation
    files:
      - bench/htif_uart_bridge_assertions.sv
      - bench/htif_uart_bridge_tb.sv
